// File: compile.f
logic/sdram_mux_pkg.sv
logic/sdram_slot.sv
logic/slot_arbiter.sv
logic/resp_tracker.sv
logic/sdram_mux.sv
sim/sdram_ctrl_model.sv
sim/sdram_mux_tb.sv

// File: Makefile
# Verilator build for the SDRAM read multiplexer testbench

VERILATOR ?= verilator
TOP       ?= sdram_mux_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= all tests passed
VFLAGS    ?= --binary --timing --assert -Wno-fatal

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sim/sdram_mux_tb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed testbench for the SDRAM read multiplexer with four slots.
// Each test is a task; a closing line gives the counts
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/1ps

module sdram_mux_tb;

    localparam int NS = 4;
    // Six tests take a few hundred cycles together
    localparam int MAX_CYCLES = 4000;
    localparam sdram_mux_pkg::sdram_addr_t OFFS [NS] =
        '{22'h000000, 22'h0C0000, 22'h180000, 22'h240000};

    logic                       clk = 1'b0;
    logic                       rst = 1'b1;
    logic [NS-1:0]              slot_cs = '0;
    sdram_mux_pkg::slot_addr_t  slot_addr [NS] = '{default: '0};
    sdram_mux_pkg::sdram_data_t slot_data [NS];
    logic [NS-1:0]              slot_ok;
    logic                       sdram_req;
    sdram_mux_pkg::sdram_addr_t sdram_addr;
    logic                       data_rdy;
    sdram_mux_pkg::sdram_data_t data_read;
    logic                       slow = 1'b0;
    logic [3:0]                 latency = 4'd2;
    logic [31:0]                lat_state = 32'habf5;
    logic [31:0]                addr_state = 32'habf5;
    int                         errors = 0;
    int                         tests_run = 0;
    int                         tests_bad = 0;
    int                         cycles = 0;
    int                         outstanding = 0;
    int                         max_outstanding = 0;
    int                         req_count = 0;
    sdram_mux_pkg::sdram_addr_t issued [$];

    sdram_mux #(.SLOTS(NS), .CREDITS(4), .SLOT_OFFSET(OFFS)) sdram_mux_i (
        .clk(clk), .rst(rst), .slot_cs(slot_cs), .slot_addr(slot_addr),
        .slot_data(slot_data), .slot_ok(slot_ok), .sdram_req(sdram_req),
        .sdram_addr(sdram_addr), .data_rdy(data_rdy), .data_read(data_read)
    );

    sdram_ctrl_model u_ctrl (
        .clk(clk), .rst(rst), .sdram_req(sdram_req), .sdram_addr(sdram_addr),
        .latency(latency), .data_rdy(data_rdy), .data_read(data_read)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Word pattern of the full address, offset included
    function automatic logic [31:0] expected_word(input int k, input sdram_mux_pkg::slot_addr_t a);
        sdram_mux_pkg::sdram_addr_t full;
        full = OFFS[k] + a;
        return (32'(full) * 32'h9E37_79B1) ^ 32'h5A5A_C3C3;
    endfunction

    // Controller latency, 2 to 9 cycles, or 9 when slowed
    always @(negedge clk) begin
        lat_state <= lcg_next(lat_state);
        latency   <= slow ? 4'd9 : 4'd2 + {1'b0, lat_state[18:16]};
    end

    // Bus monitor, sampled just after the edge
    always @(posedge clk) begin
        #1;
        if (rst) begin
            outstanding = 0;
        end else begin
            if (sdram_req) begin
                outstanding++;
                req_count++;
                issued.push_back(sdram_addr);
            end
            if (data_rdy) begin
                outstanding--;
            end
            if (outstanding > max_outstanding) begin
                max_outstanding = outstanding;
            end
            assert (outstanding <= 4) else begin
                $display("more than 4 reads outstanding at the controller");
                errors++;
            end
            for (int k = 0; k < NS; k++) begin
                if (slot_ok[k]) begin
                    assert (slot_data[k] === expected_word(k, slot_addr[k])) else begin
                        $display("[ERROR] slot_data[%0d]: got %h, expected %h", k,
                                 slot_data[k], expected_word(k, slot_addr[k]));
                        errors++;
                    end
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("run stopped after %0d cycles without finishing", cycles);
            $display("tests failed");
            $finish;
        end
    end

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_that(input logic cond, input string what);
        assert (cond) else begin
            $display("%s", what);
            errors++;
        end
    endtask

    // Lets at least one edge pass so ok reflects the current address
    task automatic wait_ok(input logic [NS-1:0] mask, input int limit);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while ((slot_ok & mask) != mask && n < limit);
        check_that((slot_ok & mask) == mask,
                   $sformatf("slots %b returned no data within %0d cycles", mask, limit));
    endtask

    task automatic end_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("PASS %s", name);
        end else begin
            tests_bad++;
            $display("FAIL %s with %0d errors", name, errors - err_before);
        end
    endtask

    task automatic single_miss();
        int e0;
        int r0;
        e0 = errors;
        r0 = req_count;
        issued.delete();
        slot_cs[0]   = 1'b1;
        slot_addr[0] = 22'h000123;
        wait_ok(4'b0001, 40);
        check_eq("slot_data[0]", slot_data[0], expected_word(0, 22'h000123));
        check_eq("request count", 32'(req_count - r0), 32'd1);
        if (issued.size() > 0) begin
            check_eq("sdram_addr", 32'(issued[0]), 32'(OFFS[0] + 22'h000123));
        end
        end_test("single_miss", e0);
    endtask

    task automatic cached_hit();
        int e0;
        int r0;
        e0 = errors;
        r0 = req_count;
        slot_cs[0] = 1'b0;
        repeat (2) @(negedge clk);
        check_that(!slot_ok[0], "slot_ok[0] stayed high with cs low");
        slot_cs[0] = 1'b1;
        wait_ok(4'b0001, 2);
        repeat (8) begin
            @(negedge clk);
            check_that(slot_ok[0], "slot_ok[0] dropped on a cached address");
        end
        check_eq("request count", 32'(req_count - r0), 32'd0);
        end_test("cached_hit", e0);
    endtask

    task automatic concurrent_misses();
        sdram_mux_pkg::slot_addr_t a [NS];
        int e0;
        int s;
        e0 = errors;
        a = '{22'h000200, 22'h000301, 22'h000402, 22'h000503};
        issued.delete();
        for (int k = 0; k < NS; k++) begin
            slot_cs[k]   = 1'b1;
            slot_addr[k] = a[k];
        end
        wait_ok(4'b1111, 60);
        for (int k = 0; k < NS; k++) begin
            check_eq($sformatf("slot_data[%0d]", k), slot_data[k], expected_word(k, a[k]));
        end
        check_eq("issued count", 32'(issued.size()), 32'd4);
        // Slot 0 was granted last, so the search begins at slot 1
        for (int i = 0; i < NS && i < issued.size(); i++) begin
            s = (i + 1) % NS;
            check_eq("sdram_addr", 32'(issued[i]), 32'(OFFS[s] + a[s]));
        end
        end_test("concurrent_misses", e0);
    endtask

    task automatic credit_back_pressure();
        int e0;
        int n;
        e0 = errors;
        slow = 1'b1;
        max_outstanding = 0;
        // Addresses move faster than reads return, leaving stale words
        repeat (12) begin
            for (int k = 0; k < NS; k++) begin
                addr_state   = lcg_next(addr_state);
                slot_addr[k] = addr_state[27:6];
            end
            repeat (3) @(negedge clk);
        end
        wait_ok(4'b1111, 200);
        for (int k = 0; k < NS; k++) begin
            check_eq($sformatf("slot_data[%0d]", k), slot_data[k],
                     expected_word(k, slot_addr[k]));
        end
        n = 0;
        while (outstanding != 0 && n < 20) begin
            @(negedge clk);
            n++;
        end
        check_that(outstanding == 0, "reads still outstanding after all slots were served");
        check_that(max_outstanding <= 4, "credit limit of 4 was exceeded");
        slow = 1'b0;
        end_test("credit_back_pressure", e0);
    endtask

    task automatic addr_change_mid_fetch();
        int e0;
        int r0;
        int n;
        e0 = errors;
        slow = 1'b1;
        r0 = req_count;
        slot_addr[1] = 22'h000777;
        n = 0;
        while (req_count == r0 && n < 20) begin
            @(negedge clk);
            n++;
        end
        check_that(req_count > r0, "no read was issued for slot 1");
        slot_addr[1] = 22'h000888;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            check_that(!(slot_ok[1] && slot_data[1] === expected_word(1, 22'h000777)),
                       "slot 1 showed data for its old address");
        end while (!slot_ok[1] && n < 80);
        check_that(slot_ok[1], "slot 1 never returned data for its new address");
        check_eq("slot_data[1]", slot_data[1], expected_word(1, 22'h000888));
        slow = 1'b0;
        end_test("addr_change_mid_fetch", e0);
    endtask

    task automatic reset_mid_activity();
        sdram_mux_pkg::slot_addr_t z;
        int e0;
        int r0;
        e0 = errors;
        z = slot_addr[2];
        slot_addr[0] = 22'h000a10;
        slot_addr[1] = 22'h000a11;
        slot_addr[3] = 22'h000a13;
        repeat (2) @(negedge clk);
        // Clients stay selected, so only reset can pull ok down
        rst = 1'b1;
        repeat (3) @(negedge clk);
        check_eq("slot_ok", 32'(slot_ok), 32'd0);
        check_eq("sdram_req", 32'(sdram_req), 32'd0);
        slot_cs = '0;
        rst     = 1'b0;
        repeat (2) @(negedge clk);
        check_eq("slot_ok", 32'(slot_ok), 32'd0);
        check_eq("sdram_req", 32'(sdram_req), 32'd0);
        // Cache was cleared, so the old address must miss
        r0 = req_count;
        issued.delete();
        slot_cs[2] = 1'b1;
        wait_ok(4'b0100, 40);
        check_eq("request count", 32'(req_count - r0), 32'd1);
        if (issued.size() > 0) begin
            check_eq("sdram_addr", 32'(issued[0]), 32'(OFFS[2] + z));
        end
        check_eq("slot_data[2]", slot_data[2], expected_word(2, z));
        end_test("reset_mid_activity", e0);
    endtask

    initial begin
        repeat (3) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        single_miss();
        cached_hit();
        concurrent_misses();
        credit_back_pressure();
        addr_change_mid_fetch();
        reset_mid_activity();
        $display("%0d tests run, %0d failing, %0d errors", tests_run, tests_bad, errors);
        if (tests_bad == 0 && errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule : sdram_mux_tb

`default_nettype wire

// File: sim/sdram_ctrl_model.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Behavioral SDRAM controller for simulation. Queues read requests and
// answers them in order after the latency given on its latency input
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/1ps

module sdram_ctrl_model (
    input  wire                             clk,
    input  wire                             rst,
    input  wire                             sdram_req,
    input  wire sdram_mux_pkg::sdram_addr_t sdram_addr,
    input  wire [3:0]                       latency,
    output logic                            data_rdy,
    output sdram_mux_pkg::sdram_data_t      data_read
);

    sdram_mux_pkg::sdram_addr_t addr_q [$];
    longint                     due_q [$];
    longint                     cyc = 0;
    longint                     last_due = 0;

    // Memory contents follow from the address alone
    function automatic sdram_mux_pkg::sdram_data_t word_at(input sdram_mux_pkg::sdram_addr_t a);
        return (32'(a) * 32'h9E37_79B1) ^ 32'h5A5A_C3C3;
    endfunction

    always @(posedge clk) begin : serve
        longint due;
        if (rst) begin
            addr_q.delete();
            due_q.delete();
            data_rdy <= 1'b0;
            cyc = 0;
            last_due = 0;
        end else begin
            cyc = cyc + 1;
            data_rdy <= 1'b0;
            if (due_q.size() > 0 && due_q[0] <= cyc) begin
                data_rdy  <= 1'b1;
                data_read <= word_at(addr_q.pop_front());
                void'(due_q.pop_front());
            end
            if (sdram_req) begin
                // In-order answers, never two in one cycle
                due = cyc + longint'(latency);
                if (due <= last_due) begin
                    due = last_due + 1;
                end
                last_due = due;
                addr_q.push_back(sdram_addr);
                due_q.push_back(due);
            end
        end
    end

endmodule : sdram_ctrl_model

`default_nettype wire

// File: logic/sdram_mux.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Multi-client SDRAM read multiplexer. One read slot per client,
// a round-robin arbiter towards the controller and a response tracker
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/1ps

module sdram_mux #(
    parameter int SLOTS   = sdram_mux_pkg::DEFAULT_SLOTS,
    parameter int CREDITS = sdram_mux_pkg::DEFAULT_CREDITS,
    parameter sdram_mux_pkg::sdram_addr_t SLOT_OFFSET [SLOTS] = '{default: '0}
) (
    input  wire                         clk,
    input  wire                         rst,
    // Client side
    input  wire [SLOTS-1:0]             slot_cs,
    input  wire sdram_mux_pkg::slot_addr_t  slot_addr [SLOTS],
    output sdram_mux_pkg::sdram_data_t  slot_data [SLOTS],
    output logic [SLOTS-1:0]            slot_ok,
    // SDRAM controller
    output logic                        sdram_req,
    output sdram_mux_pkg::sdram_addr_t  sdram_addr,
    input  wire                         data_rdy,
    input  wire sdram_mux_pkg::sdram_data_t data_read
);

    localparam int IW = (SLOTS > 1) ? $clog2(SLOTS) : 1;

    wire [SLOTS-1:0]                req;
    wire sdram_mux_pkg::sdram_addr_t req_addr [SLOTS];
    wire [SLOTS-1:0]                grant;
    wire [SLOTS-1:0]                resp_valid;
    wire sdram_mux_pkg::sdram_data_t resp_data;
    wire                            credit_ok;
    wire                            issue;
    wire [IW-1:0]                   issue_slot;

    for (genvar k = 0; k < SLOTS; k++) begin : g_slot
        sdram_slot #(.OFFSET(SLOT_OFFSET[k])) u_slot (
            .clk        ( clk           ),
            .rst        ( rst           ),
            .cs         ( slot_cs[k]    ),
            .addr       ( slot_addr[k]  ),
            .data       ( slot_data[k]  ),
            .ok         ( slot_ok[k]    ),
            .req        ( req[k]        ),
            .req_addr   ( req_addr[k]   ),
            .grant      ( grant[k]      ),
            .resp_valid ( resp_valid[k] ),
            .resp_data  ( resp_data     )
        );
    end

    slot_arbiter #(.SLOTS(SLOTS), .CREDITS(CREDITS)) u_arbiter (
        .clk(clk), .rst(rst), .req(req), .req_addr(req_addr),
        .credit_ok(credit_ok), .grant(grant), .sdram_req(sdram_req),
        .sdram_addr(sdram_addr), .issue(issue), .issue_slot(issue_slot)
    );

    // Words come back in issue order
    resp_tracker #(.SLOTS(SLOTS), .CREDITS(CREDITS)) u_tracker (
        .clk(clk), .rst(rst), .issue(issue), .issue_slot(issue_slot),
        .data_rdy(data_rdy), .data_read(data_read), .credit_ok(credit_ok),
        .resp_valid(resp_valid), .resp_data(resp_data)
    );

endmodule : sdram_mux

`default_nettype wire

// File: logic/resp_tracker.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Credit counter and in-order queue of slot indexes. Each word from
// the controller goes back to the slot that asked for it
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/1ps

module resp_tracker #(
    parameter int  SLOTS   = sdram_mux_pkg::DEFAULT_SLOTS,
    parameter int  CREDITS = sdram_mux_pkg::DEFAULT_CREDITS,
    localparam int IW      = (SLOTS > 1) ? $clog2(SLOTS) : 1
) (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         issue,
    input  wire [IW-1:0]                issue_slot,
    input  wire                         data_rdy,
    input  wire sdram_mux_pkg::sdram_data_t data_read,
    output logic                        credit_ok,
    output logic [SLOTS-1:0]            resp_valid,
    output sdram_mux_pkg::sdram_data_t  resp_data
);

    localparam int PW = (CREDITS > 1) ? $clog2(CREDITS) : 1;
    localparam int CW = $clog2(CREDITS + 1);

    // One entry per outstanding read
    logic [IW-1:0] fifo [CREDITS];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] credits;
    logic          fifo_empty;

    function automatic logic [PW-1:0] ptr_next(input logic [PW-1:0] p);
        return (int'(p) == CREDITS - 1) ? '0 : p + 1'b1;
    endfunction

    assign fifo_empty = (credits == CW'(CREDITS));

    // The arbiter decides a cycle before issue lands on the count,
    // so a credit being spent right now is not offered again
    assign credit_ok = (credits > CW'(issue));

    always_ff @(posedge clk) begin
        if (rst) begin
            credits    <= CW'(CREDITS);
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            resp_valid <= '0;
        end else begin
            resp_valid <= '0;
            if (issue && !data_rdy) begin
                credits <= credits - 1'b1;
            end else if (data_rdy && !issue) begin
                credits <= credits + 1'b1;
            end
            if (issue) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (data_rdy) begin
                rd_ptr     <= ptr_next(rd_ptr);
                resp_valid <= SLOTS'(1) << fifo[rd_ptr];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            fifo[wr_ptr] <= issue_slot;
        end
        if (data_rdy) begin
            resp_data <= data_read;
        end
    end

    // Controller never answers a read that was not issued
    a_no_orphan_data: assert property (@(posedge clk) disable iff (rst)
        data_rdy |-> !fifo_empty);

    a_credit_bound: assert property (@(posedge clk) disable iff (rst)
        credits <= CW'(CREDITS));

endmodule : resp_tracker

`default_nettype wire

// File: logic/slot_arbiter.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Round-robin arbiter between slot requests. Issues one SDRAM read
// per cycle at most, and only while the tracker reports a credit
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/1ps

module slot_arbiter #(
    parameter int  SLOTS   = sdram_mux_pkg::DEFAULT_SLOTS,
    parameter int  CREDITS = sdram_mux_pkg::DEFAULT_CREDITS,
    localparam int IW      = (SLOTS > 1) ? $clog2(SLOTS) : 1
) (
    input  wire                         clk,
    input  wire                         rst,
    input  wire [SLOTS-1:0]             req,
    input  wire sdram_mux_pkg::sdram_addr_t req_addr [SLOTS],
    input  wire                         credit_ok,
    output logic [SLOTS-1:0]            grant,
    output logic                        sdram_req,
    output sdram_mux_pkg::sdram_addr_t  sdram_addr,
    output logic                        issue,
    output logic [IW-1:0]               issue_slot
);

    if (CREDITS < 1) begin : g_credit_check
        $error("slot_arbiter needs at least one controller credit");
    end

    logic [SLOTS-1:0] pending;
    logic [IW-1:0]    last;
    logic [IW-1:0]    pick;
    logic             found;
    int               idx;

    // A granted slot keeps req up for one more cycle
    assign pending = req & ~grant;

    // Search starts at the slot after the last one granted
    always_comb begin
        found = 1'b0;
        pick  = '0;
        idx   = 0;
        for (int i = 1; i <= SLOTS; i++) begin
            idx = (int'(last) + i) % SLOTS;
            if (!found && pending[idx]) begin
                found = 1'b1;
                pick  = IW'(idx);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            grant     <= '0;
            sdram_req <= 1'b0;
            last      <= IW'(SLOTS - 1);
        end else begin
            grant     <= '0;
            sdram_req <= 1'b0;
            if (credit_ok && found) begin
                grant[pick] <= 1'b1;
                sdram_req   <= 1'b1;
                last        <= pick;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (credit_ok && found) begin
            sdram_addr <= req_addr[pick];
            issue_slot <= pick;
        end
    end

    // Tracker records the slot in the same cycle as the controller request
    assign issue = sdram_req;

    a_grant_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(grant) && ((|grant) == sdram_req));

endmodule : slot_arbiter

`default_nettype wire

// File: logic/sdram_slot.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Read slot for one client. Adds the region offset, keeps the last
// fetched word and raises a request to the arbiter on a miss
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/1ps

module sdram_slot #(
    parameter sdram_mux_pkg::sdram_addr_t OFFSET = '0
) (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         cs,
    input  wire sdram_mux_pkg::slot_addr_t  addr,
    output sdram_mux_pkg::sdram_data_t  data,
    output logic                        ok,
    output logic                        req,
    output sdram_mux_pkg::sdram_addr_t  req_addr,
    input  wire                         grant,
    input  wire                         resp_valid,
    input  wire sdram_mux_pkg::sdram_data_t resp_data
);

    // Address of the word held in data
    sdram_mux_pkg::slot_addr_t cache_addr;
    logic                      cache_valid;
    // Address of the fetch in flight
    sdram_mux_pkg::slot_addr_t fetch_addr;
    logic                      busy;

    logic hit;
    logic miss;
    logic fill;

    assign hit  = cache_valid && (cache_addr == addr);
    assign miss = cs && !hit && !busy && !req;
    // Stale words are dropped, the slot asks again once idle
    assign fill = resp_valid && (fetch_addr == addr);

    always_ff @(posedge clk) begin
        if (rst) begin
            cache_valid <= 1'b0;
            busy        <= 1'b0;
            req         <= 1'b0;
            ok          <= 1'b0;
        end else begin
            // A returning word can raise ok in the cycle it is written
            ok <= cs && (fill || hit);
            if (resp_valid) begin
                busy <= 1'b0;
            end
            if (fill) begin
                cache_valid <= 1'b1;
            end
            if (grant) begin
                req  <= 1'b0;
                busy <= 1'b1;
            end else if (miss) begin
                req <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            cache_addr <= fetch_addr;
            data       <= resp_data;
        end
        if (miss) begin
            fetch_addr <= addr;
            req_addr   <= OFFSET + sdram_mux_pkg::sdram_addr_t'(addr);
        end
    end

    // Arbiter only grants slots that are asking
    a_grant_needs_req: assert property (@(posedge clk) disable iff (rst)
        grant |-> req);

    // Tracker only routes data to a slot with a fetch outstanding
    a_resp_needs_busy: assert property (@(posedge clk) disable iff (rst)
        resp_valid |-> busy);

endmodule : sdram_slot

`default_nettype wire

// File: logic/sdram_mux_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared vector types and default sizes for the SDRAM read multiplexer
// Modules refer to these through scoped names
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package sdram_mux_pkg;

    // Full word address as seen by the SDRAM controller
    typedef logic [21:0] sdram_addr_t;

    // One word returned by the controller
    typedef logic [31:0] sdram_data_t;

    // Client address inside its own region, before the offset is added
    typedef logic [21:0] slot_addr_t;

    // Number of client read slots
    localparam int DEFAULT_SLOTS = 4;

    // Controller queue depth, one credit per entry
    localparam int DEFAULT_CREDITS = 4;

endpackage : sdram_mux_pkg

`default_nettype wire
